//--- Makefile
TOP := tb_exec_cluster

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

//--- alu_select.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

module alu_select (
    input  logic                        issue_valid,

    // Busy level per unit
    input  logic [`EXEC_NUM_ALUS-1:0]   unit_busy,

    // One-hot capture strobe to the units
    output logic [`EXEC_NUM_ALUS-1:0]   dispatch,
    output logic                        issue_ready
);

    logic [`EXEC_NUM_ALUS-1:0] unit_free;
    logic [`EXEC_NUM_ALUS-1:0] first_free;
    logic                      found;

    assign unit_free = ~unit_busy;

    //////////////////////////////////////////////////
    // Priority pick
    //////////////////////////////////////////////////

    // Lowest index wins
    always_comb begin
        first_free = '0;
        found      = 1'b0;
        for (int i = 0; i < `EXEC_NUM_ALUS; i++) begin
            if (unit_free[i] && !found) begin
                first_free[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Strobe only on a real issue
    assign dispatch = issue_valid ? first_free : '0;

    // Ready while any unit can take work
    assign issue_ready = |unit_free;

endmodule

//--- alu_unit.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

module alu_unit (
    input  logic                       clk,
    input  logic                       rstn,

    // Capture strobe from the selector
    input  logic                       dispatch,
    input  exec_pkg::exec_operands_t   operands,

    // High while a register result is pending
    output logic                       busy,
    output exec_pkg::wb_lane_t         lane
);

    import exec_pkg::*;

    unit_state_e                state;
    logic                       accept;
    logic [`EXEC_SHAMT_W-1:0]   issue_shamt;
    logic [`EXEC_XLEN-1:0]      issue_result;

    // Held micro-op
    alu_op_e                    hold_op;
    logic [`EXEC_TAG_W-1:0]     hold_dest;
    logic                       hold_mem;
    logic [`EXEC_XLEN-1:0]      hold_val;
    logic [`EXEC_SHAMT_W-1:0]   shift_cnt;

    // Lane register
    logic                       lane_valid;
    logic                       lane_mem;
    alu_op_e                    lane_op;
    logic [`EXEC_TAG_W-1:0]     lane_dest;
    logic [`EXEC_XLEN-1:0]      lane_data;

    // NOP dispatch leaves the unit idle
    assign accept      = dispatch && (operands.op != ALU_NOP);
    assign issue_shamt = operands.imm[`EXEC_SHAMT_W-1:0];

    //////////////////////////////////////////////////
    // Single-cycle compute
    //////////////////////////////////////////////////

    always_comb begin
        case (operands.op)
            ALU_ADD:  issue_result = operands.opa + operands.opb;
            ALU_ADDI: issue_result = operands.opa + operands.imm;
            ALU_LUI:  issue_result = operands.imm;
            ALU_ORI:  issue_result = operands.opa | operands.imm;
            ALU_XOR:  issue_result = operands.opa ^ operands.opb;
            // Shifter start value
            ALU_SRAI: issue_result = operands.opa;
            // Memory ops: address only
            ALU_LB, ALU_LW, ALU_SB, ALU_SW: begin
                issue_result = operands.opa + operands.imm;
            end
            default:  issue_result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else if (accept) begin
            // Zero shift behaves like any single-cycle op
            if ((operands.op == ALU_SRAI) && (issue_shamt != '0)) begin
                state <= SHIFT;
            end else begin
                state <= DONE;
            end
        end else begin
            case (state)
                SHIFT:   if (shift_cnt == 1) state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Operand hold and serial shifter, one bit per cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_op   <= operands.op;
            hold_dest <= operands.dest;
            hold_mem  <= operands.is_mem;
            hold_val  <= issue_result;
            shift_cnt <= issue_shamt;
        end else if (state == SHIFT) begin
            // Sign bit replicated
            hold_val  <= $signed(hold_val) >>> 1;
            shift_cnt <= shift_cnt - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Writeback lane
    //////////////////////////////////////////////////

    // One-cycle valid pulse after DONE
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= (state == DONE);
        end
    end

    always_ff @(posedge clk) begin
        if (state == DONE) begin
            lane_mem  <= hold_mem;
            lane_op   <= hold_op;
            lane_dest <= hold_dest;
            lane_data <= hold_val;
        end
    end

    assign lane = '{valid: lane_valid, is_mem: lane_mem, op: lane_op,
                    dest: lane_dest, data: lane_data};

    // Memory ops pass through without occupying the unit
    assign busy = (state != IDLE) && !hold_mem;

endmodule

//--- exec_cluster.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

module exec_cluster (
    input  logic                      clk,
    input  logic                      rstn,

    // Issue side
    input  logic                      issue_valid,
    input  exec_pkg::uop_t            issue_uop,
    output logic                      issue_ready,

    // External register write
    input  logic                      ext_wr_en,
    input  logic [`EXEC_TAG_W-1:0]    ext_wr_tag,
    input  logic [`EXEC_XLEN-1:0]     ext_wr_data,

    // One lane per unit
    output exec_pkg::wb_lane_t        wb_lanes [`EXEC_NUM_ALUS]
);

    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0]      rd_data_a;
    logic [`EXEC_XLEN-1:0]      rd_data_b;
    logic [`EXEC_NUM_ALUS-1:0]  dispatch;
    logic [`EXEC_NUM_ALUS-1:0]  unit_busy;
    exec_operands_t             issue_ops;

    //////////////////////////////////////////////////
    // Operand fetch
    //////////////////////////////////////////////////

    phys_regfile u_regfile (
        .clk         (clk),
        .rstn        (rstn),
        .rd_tag_a    (issue_uop.src1),
        .rd_tag_b    (issue_uop.src2),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .wb_lanes    (wb_lanes),
        .ext_wr_en   (ext_wr_en),
        .ext_wr_tag  (ext_wr_tag),
        .ext_wr_data (ext_wr_data)
    );

    // Broadcast bundle, one unit captures it
    always_comb begin
        issue_ops.op     = issue_uop.op;
        issue_ops.opa    = rd_data_a;
        issue_ops.opb    = rd_data_b;
        issue_ops.imm    = issue_uop.imm;
        issue_ops.dest   = issue_uop.dest;
        // LB, LW, SB, SW
        issue_ops.is_mem = issue_uop.op inside {[ALU_LB:ALU_SW]};
        issue_ops.rsvd   = 1'b0;
    end

    //////////////////////////////////////////////////
    // Unit select and ALUs
    //////////////////////////////////////////////////

    alu_select u_select (
        .issue_valid (issue_valid),
        .unit_busy   (unit_busy),
        .dispatch    (dispatch),
        .issue_ready (issue_ready)
    );

    for (genvar i = 0; i < `EXEC_NUM_ALUS; i++) begin : g_alu
        alu_unit u_alu (
            .clk      (clk),
            .rstn     (rstn),
            .dispatch (dispatch[i]),
            .operands (issue_ops),
            .busy     (unit_busy[i]),
            .lane     (wb_lanes[i])
        );
    end

endmodule

//--- exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath sizes
//////////////////////////////////////////////////

// Integer data word
`define EXEC_XLEN 32

// Physical register tag, one of 64 entries
`define EXEC_TAG_W 6

// Size of the physical register file
`define EXEC_NUM_PREGS 64

//////////////////////////////////////////////////
// Execute resources
//////////////////////////////////////////////////

// ALU functional units, one writeback lane each
`define EXEC_NUM_ALUS 3

// Shift amount field taken from imm[4:0]
`define EXEC_SHAMT_W 5

`endif

//--- exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Opcode values as decoded by the issue stage
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_ADDI = 4'd2,
        ALU_LUI  = 4'd3,
        ALU_ORI  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRAI = 4'd6,
        ALU_LB   = 4'd7,
        ALU_LW   = 4'd8,
        ALU_SB   = 4'd9,
        ALU_SW   = 4'd10
    } alu_op_e;

    // Per-unit sequencing
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        SHIFT = 2'd1,
        DONE  = 2'd2
    } unit_state_e;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    // Micro-op from the issue stage, 54 bits
    typedef struct packed {
        alu_op_e                 op;
        logic [`EXEC_TAG_W-1:0]  src1;
        logic [`EXEC_TAG_W-1:0]  src2;
        logic [`EXEC_XLEN-1:0]   imm;
        logic [`EXEC_TAG_W-1:0]  dest;
    } uop_t;

    // Operands broadcast to all units, 108 bits
    typedef struct packed {
        alu_op_e                 op;
        logic [`EXEC_XLEN-1:0]   opa;
        logic [`EXEC_XLEN-1:0]   opb;
        logic [`EXEC_XLEN-1:0]   imm;
        logic [`EXEC_TAG_W-1:0]  dest;
        logic                    is_mem;
        logic                    rsvd;
    } exec_operands_t;

    // Writeback lane, data is the address when is_mem is set
    typedef struct packed {
        logic                    valid;
        logic                    is_mem;
        alu_op_e                 op;
        logic [`EXEC_TAG_W-1:0]  dest;
        logic [`EXEC_XLEN-1:0]   data;
    } wb_lane_t;

endpackage

//--- flist.f
+incdir+.
exec_pkg.sv
phys_regfile.sv
alu_select.sv
alu_unit.sv
exec_cluster.sv
tb_exec_cluster.sv

//--- phys_regfile.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

module phys_regfile (
    input  logic                      clk,
    input  logic                      rstn,

    // Operand read ports, used in the cycle of issue
    input  logic [`EXEC_TAG_W-1:0]    rd_tag_a,
    input  logic [`EXEC_TAG_W-1:0]    rd_tag_b,
    output logic [`EXEC_XLEN-1:0]     rd_data_a,
    output logic [`EXEC_XLEN-1:0]     rd_data_b,

    // Result lanes from the units
    input  exec_pkg::wb_lane_t        wb_lanes [`EXEC_NUM_ALUS],

    // Load return and initial values
    input  logic                      ext_wr_en,
    input  logic [`EXEC_TAG_W-1:0]    ext_wr_tag,
    input  logic [`EXEC_XLEN-1:0]     ext_wr_data
);

    // Storage
    logic [`EXEC_XLEN-1:0] regs [`EXEC_NUM_PREGS];

    //////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // Every register reads zero after reset
            for (int i = 0; i < `EXEC_NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // One write per lane in its valid cycle
            for (int l = 0; l < `EXEC_NUM_ALUS; l++) begin
                // Address-only lanes carry no register result
                if (wb_lanes[l].valid && !wb_lanes[l].is_mem &&
                    (wb_lanes[l].dest != '0)) begin
                    regs[wb_lanes[l].dest] <= wb_lanes[l].data;
                end
            end
            // External port last, so it wins on a tag clash
            if (ext_wr_en && (ext_wr_tag != '0)) begin
                regs[ext_wr_tag] <= ext_wr_data;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    // No bypass; entry 0 never written, so stays zero
    assign rd_data_a = regs[rd_tag_a];
    assign rd_data_b = regs[rd_tag_b];

endmodule

//--- tb_exec_cluster.sv
`timescale 1ns/1ns
`include "exec_defines.svh"

module tb_exec_cluster;

    import exec_pkg::*;

    // One issued micro-op and the lane it should produce
    typedef struct packed {
        alu_op_e                 op;
        logic [`EXEC_TAG_W-1:0]  dest;
        logic [`EXEC_XLEN-1:0]   data;
        logic                    is_mem;
        int                      cycle;
        int                      lane;
        logic                    done;
    } exp_rec_t;

    logic                       clk;
    logic                       rstn;
    logic                       issue_valid;
    uop_t                       issue_uop;
    logic                       issue_ready;
    logic                       ext_wr_en;
    logic [`EXEC_TAG_W-1:0]     ext_wr_tag;
    logic [`EXEC_XLEN-1:0]      ext_wr_data;
    wb_lane_t                   wb_lanes [`EXEC_NUM_ALUS];

    // Register model updated at issue
    logic [`EXEC_XLEN-1:0]      model_regs [`EXEC_NUM_PREGS];
    logic                       reg_pending [`EXEC_NUM_PREGS];
    exp_rec_t                   recs [0:511];
    int                         rec_count;
    int                         cycle_cnt;
    int                         value_errs;
    int                         timing_errs;
    int                         other_errs;
    logic [31:0]                lfsr_state;
    alu_op_e                    op_list [10];

    exec_cluster u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop),
        .issue_ready (issue_ready),
        .ext_wr_en   (ext_wr_en),
        .ext_wr_tag  (ext_wr_tag),
        .ext_wr_data (ext_wr_data),
        .wb_lanes    (wb_lanes)
    );

    //////////////////////////////////////////////////
    // Clock, cycle count, random bits
    //////////////////////////////////////////////////

    always #10 clk = ~clk;

    // Equals the edge number when read at a falling edge
    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [`EXEC_XLEN-1:0] ref_result(input alu_op_e op,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm);
        logic signed [31:0] sa;
        sa = a;
        case (op)
            ALU_ADD:  return a + b;
            ALU_ADDI: return a + imm;
            ALU_LUI:  return imm;
            ALU_ORI:  return a | imm;
            ALU_XOR:  return a ^ b;
            // Arithmetic shift fills with the sign bit
            ALU_SRAI: return sa >>> imm[4:0];
            // Address only
            ALU_LB, ALU_LW, ALU_SB, ALU_SW: return a + imm;
            default:  return '0;
        endcase
    endfunction

    function automatic logic is_mem_op(input alu_op_e op);
        return op inside {ALU_LB, ALU_LW, ALU_SB, ALU_SW};
    endfunction

    function automatic int open_count();
        int n;
        n = 0;
        for (int i = 0; i < rec_count; i++) begin
            if (!recs[i].done) n++;
        end
        return n;
    endfunction

    // Random tag that is not in flight
    function automatic int pick_tag(input logic nonzero);
        logic [5:0] t;
        t = 6'(rand_bits(6));
        for (int i = 0; i < 64; i++) begin
            if (reg_pending[t] || (nonzero && t == 0)) t = t + 6'd1;
        end
        return int'(t);
    endfunction

    //////////////////////////////////////////////////
    // Stimulus tasks entered and left 2 ns after a rising edge
    //////////////////////////////////////////////////

    task automatic ext_write(input int tag, input logic [31:0] data);
        ext_wr_en   = 1'b1;
        ext_wr_tag  = 6'(tag);
        ext_wr_data = data;
        @(posedge clk);
        #2;
        ext_wr_en = 1'b0;
        if (tag != 0) model_regs[tag] = data;
    endtask

    // Lane -1 when any unit may take it
    task automatic send_uop(input alu_op_e op, input int s1, input int s2,
            input logic [31:0] imm, input int dest, input int lane);
        exp_rec_t r;
        int       n;
        issue_uop   = '{op: op, src1: 6'(s1), src2: 6'(s2), imm: imm, dest: 6'(dest)};
        issue_valid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!issue_ready && n < 100) begin
            n++;
            @(negedge clk);
        end
        if (!issue_ready) begin
            other_errs++;
            $display("Timeout at %0t: issue_ready stayed low for 100 cycles", $time);
        end else begin
            r.op     = op;
            r.dest   = 6'(dest);
            r.is_mem = is_mem_op(op);
            r.data   = ref_result(op, model_regs[s1], model_regs[s2], imm);
            // Accepted at the next edge and valid one edge later plus the shift
            r.cycle  = cycle_cnt + 2 + ((op == ALU_SRAI) ? int'(imm[4:0]) : 0);
            r.lane   = lane;
            r.done   = 1'b0;
            recs[rec_count] = r;
            rec_count++;
            if (!r.is_mem && dest != 0) begin
                model_regs[dest]  = r.data;
                reg_pending[dest] = 1'b1;
            end
        end
        @(posedge clk);
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic wait_all_done(input int limit);
        int n;
        n = 0;
        while (open_count() > 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        #2;
        if (open_count() > 0) begin
            other_errs++;
            $display("Timeout at %0t: %0d issued micro-ops never completed",
                     $time, open_count());
            for (int i = 0; i < rec_count; i++) recs[i].done = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Lane checker
    //////////////////////////////////////////////////

    task automatic check_lane(input int l);
        int idx;
        idx = -1;
        // Oldest open record with this dest and op
        for (int i = 0; i < rec_count; i++) begin
            if (idx < 0 && !recs[i].done && recs[i].dest == wb_lanes[l].dest &&
                recs[i].op == wb_lanes[l].op) idx = i;
        end
        assert (idx >= 0) else begin
            other_errs++;
            $display("Lane %0d gave a result at %0t that no issued micro-op explains",
                     l, $time);
        end
        if (idx >= 0) begin
            recs[idx].done = 1'b1;
            if (!recs[idx].is_mem) reg_pending[recs[idx].dest] = 1'b0;
            assert (wb_lanes[l].data == recs[idx].data) else begin
                value_errs++;
                $display("[ERROR] %0t: lane %0d dest %0d data %h, expected %h", $time, l,
                         wb_lanes[l].dest, wb_lanes[l].data, recs[idx].data);
            end
            assert (wb_lanes[l].is_mem == recs[idx].is_mem) else begin
                value_errs++;
                $display("[ERROR] %0t: lane %0d is_mem %0b, expected %0b", $time, l,
                         wb_lanes[l].is_mem, recs[idx].is_mem);
            end
            assert (cycle_cnt == recs[idx].cycle) else begin
                timing_errs++;
                $display("[ERROR] %0t: lane %0d valid in cycle %0d, expected cycle %0d",
                         $time, l, cycle_cnt, recs[idx].cycle);
            end
            assert ((recs[idx].lane == -1) || (recs[idx].lane == l)) else begin
                value_errs++;
                $display("[ERROR] %0t: result on lane %0d, expected lane %0d", $time, l,
                         recs[idx].lane);
            end
        end
    endtask

    // Lanes are stable at the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            for (int l = 0; l < `EXEC_NUM_ALUS; l++) begin
                if (wb_lanes[l].valid) check_lane(l);
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int first;
        int n;
        clk         = 1'b0;
        rstn        = 1'b0;
        issue_valid = 1'b0;
        issue_uop   = '0;
        ext_wr_en   = 1'b0;
        ext_wr_tag  = '0;
        ext_wr_data = '0;
        cycle_cnt   = 0;
        rec_count   = 0;
        value_errs  = 0;
        timing_errs = 0;
        other_errs  = 0;
        lfsr_state  = 32'h0047_8f6d;
        op_list = '{ALU_ADD, ALU_ADDI, ALU_LUI, ALU_ORI, ALU_XOR,
                    ALU_SRAI, ALU_LB, ALU_LW, ALU_SB, ALU_SW};
        for (int i = 0; i < `EXEC_NUM_PREGS; i++) begin
            model_regs[i]  = '0;
            reg_pending[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;

        // Idle state after reset
        @(negedge clk);
        assert (issue_ready) else begin
            value_errs++;
            $display("[ERROR] %0t: issue_ready low after reset", $time);
        end
        for (int l = 0; l < `EXEC_NUM_ALUS; l++) begin
            assert (!wb_lanes[l].valid) else begin
                value_errs++;
                $display("[ERROR] %0t: lane %0d valid after reset", $time, l);
            end
        end
        @(posedge clk);
        #2;

        // Single ops on lane 0 each followed by a dependent ADD
        for (int t = 1; t < 9; t++) ext_write(t, rand_bits(32));
        for (int i = 0; i < 5; i++) begin
            send_uop(op_list[i], 1 + i, 2 + i, rand_bits(32), 10 + i, 0);
            wait_all_done(20);
            send_uop(ALU_ADD, 10 + i, 1, '0, 20 + i, 0);
            wait_all_done(20);
        end

        // Serial shift of negative operands
        for (int i = 0; i < 8; i++) begin
            ext_write(2, rand_bits(32) | 32'h8000_0000);
            send_uop(ALU_SRAI, 2, 0, rand_bits(32), 30, 0);
            wait_all_done(60);
        end

        // Back-to-back address ops never occupy unit 0
        for (int i = 6; i < 10; i++) begin
            send_uop(op_list[i], 3, 4, rand_bits(32), 5, 0);
        end
        wait_all_done(20);
        // Destination of an address op stays unchanged
        send_uop(ALU_ADD, 5, 0, '0, 40, 0);
        wait_all_done(20);

        // Three long shifts fill every unit
        ext_write(6, rand_bits(32) | 32'h8000_0000);
        first = rec_count;
        send_uop(ALU_SRAI, 6, 0, 32'd20, 41, 0);
        send_uop(ALU_SRAI, 6, 0, 32'd25, 42, 1);
        send_uop(ALU_SRAI, 6, 0, 32'd30, 43, 2);
        @(negedge clk);
        assert (!issue_ready) else begin
            value_errs++;
            $display("[ERROR] %0t: issue_ready high with all units busy", $time);
        end
        n = 0;
        while (!issue_ready && n < 100) begin
            n++;
            @(negedge clk);
        end
        assert (issue_ready && cycle_cnt == recs[first].cycle) else begin
            timing_errs++;
            $display("[ERROR] %0t: issue_ready back in cycle %0d, expected cycle %0d",
                     $time, cycle_cnt, recs[first].cycle);
        end
        @(posedge clk);
        #2;
        wait_all_done(100);

        // Random mix over fresh register values
        for (int t = 1; t < `EXEC_NUM_PREGS; t++) ext_write(t, rand_bits(32));
        for (int i = 0; i < 60; i++) begin
            send_uop(op_list[int'(rand_bits(4)) % 10], pick_tag(1'b0), pick_tag(1'b0),
                     rand_bits(32), pick_tag(1'b1), -1);
        end
        wait_all_done(200);

        $display("Errors: value %0d, timing %0d, other %0d",
                 value_errs, timing_errs, other_errs);
        if (value_errs + timing_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
